/* filelist.f */
hdl/mcu_io_pkg.sv
hdl/uart_rx_writer.sv
hdl/data_mem.sv
hdl/uart_dump_tx.sv
hdl/mcu_io_top.sv
testbench/tb_clkgen.sv
testbench/tb_mcu_io.sv

/* hdl/data_mem.sv */
/*
 * Data memory
 * Word-wide storage with a byte-lane write port from the protocol
 * side and a separate one-cycle registered read port
 */
`timescale 1ns/1ps
module data_mem (
	input  logic                 clk_i,
	input  mcu_io_pkg::dm_addr_t con_addr_i,
	input  mcu_io_pkg::dm_be_t   con_write_i,
	input  mcu_io_pkg::dm_data_t con_in_i,
	input  mcu_io_pkg::dm_addr_t rd_addr_i,
	output mcu_io_pkg::dm_data_t con_out_o
);
	import mcu_io_pkg::*;

	localparam int LANE_W = $bits(uart_byte_t);

	// Storage array
	dm_data_t mem_q [DM_DEPTH];

	// Each enable bit writes its own byte lane
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < $bits(dm_be_t); i++) begin
			if (con_write_i[i]) begin
				mem_q[con_addr_i][LANE_W*i +: LANE_W] <= con_in_i[LANE_W*i +: LANE_W];
			end
		end
	end

	// Read data valid the cycle after the address
	// Same-cycle write to the same word returns old data
	always_ff @(posedge clk_i) begin
		con_out_o <= mem_q[rd_addr_i];
	end

endmodule

/* hdl/mcu_io_pkg.sv */
/*
 * MCU protocol-controller I/O package
 * Shared vector types, FSM encodings and serial timing constants
 * for the UART receive writer, data memory and dump engine
 */
package mcu_io_pkg;

	// Data memory geometry
	localparam int DM_DEPTH = 2048;
	localparam int DM_AW = $clog2(DM_DEPTH);

	// Frame layout, 4 bytes per word
	localparam int FRAME_BYTES = 16;
	localparam int FRAME_WORDS = FRAME_BYTES / 4;

	// Serial bit period in clock cycles
	localparam int CLKS_PER_BIT = 8;

	// Pending frame counter ceiling
	localparam int PEND_MAX = 15;

	// Memory port vectors
	typedef logic [DM_AW-1:0] dm_addr_t;
	typedef logic [31:0]      dm_data_t;
	typedef logic [3:0]       dm_be_t;

	// One serial character
	typedef logic [7:0] uart_byte_t;

	// Bit period timer
	typedef logic [3:0] bit_cnt_t;

	// Last cycle of a full bit, and of half a bit for start qualification
	localparam bit_cnt_t BIT_END  = bit_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_cnt_t HALF_END = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// Dump engine FSM
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_READ,
		TX_LOAD,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

/* hdl/mcu_io_top.sv */
/*
 * MCU protocol-controller I/O top level
 * UART receive writer fills data memory, dump engine sends the
 * completed frames back out with a checksum per frame
 */
`timescale 1ns/1ps
module mcu_io_top (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic uart_dec_i,
	output logic uart_enc_o,
	output logic int_sig_o,
	output logic frame_err_o
);
	import mcu_io_pkg::*;

	// Protocol-side memory write port
	dm_addr_t con_addr;
	dm_be_t   con_write;
	dm_data_t con_in;

	// Dump-side read port
	dm_addr_t rd_addr;
	dm_data_t con_out;

	// Receiver and memory writer
	uart_rx_writer uart_rx_writer_i (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.uart_dec_i  (uart_dec_i),
		.con_addr_o  (con_addr),
		.con_write_o (con_write),
		.con_in_o    (con_in),
		.int_sig_o   (int_sig_o),
		.frame_err_o (frame_err_o)
	);

	// Frame buffer
	data_mem data_mem_i (
		.clk_i       (clk_i),
		.con_addr_i  (con_addr),
		.con_write_i (con_write),
		.con_in_i    (con_in),
		.rd_addr_i   (rd_addr),
		.con_out_o   (con_out)
	);

	// Interrupt doubles as the frame-ready strobe
	uart_dump_tx uart_dump_tx_i (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.int_sig_i  (int_sig_o),
		.rd_addr_o  (rd_addr),
		.con_out_i  (con_out),
		.uart_enc_o (uart_enc_o)
	);

endmodule

/* hdl/uart_dump_tx.sv */
/*
 * Data memory dump engine
 * Counts completed frames, reads each one back word by word and
 * sends its bytes on the encoder line, then a modulo-256 checksum
 */
`timescale 1ns/1ps
module uart_dump_tx (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 int_sig_i,
	output mcu_io_pkg::dm_addr_t rd_addr_o,
	input  mcu_io_pkg::dm_data_t con_out_i,
	output logic                 uart_enc_o
);
	import mcu_io_pkg::*;

	// Control state
	tx_state_t                      state_q;
	logic [$clog2(PEND_MAX+1)-1:0]  pend_q;
	dm_addr_t                       rd_ptr_q;
	logic [$clog2(FRAME_WORDS)-1:0] word_cnt_q;
	logic [1:0]                     lane_q;
	logic                           csum_phase_q;
	bit_cnt_t                       bit_cnt_q;
	logic [2:0]                     bit_idx_q;

	// Payload
	dm_data_t   word_q;
	uart_byte_t shift_q;
	uart_byte_t csum_q;

	uart_byte_t next_byte;
	logic       bit_end;
	logic       frame_done;

	assign bit_end    = (bit_cnt_q == BIT_END);
	// Checksum stop bit finished
	assign frame_done = (state_q == TX_STOP) && bit_end && csum_phase_q;
	// Following lane of the held word
	assign next_byte  = word_q[{lane_q + 2'd1, 3'b000} +: 8];

	// Pending frames, saturating
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pend_q <= '0;
		end else if (int_sig_i && !frame_done) begin
			if (pend_q != PEND_MAX) begin
				pend_q <= pend_q + 1'b1;
			end
		end else if (!int_sig_i && frame_done) begin
			pend_q <= pend_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q      <= TX_IDLE;
			rd_ptr_q     <= '0;
			word_cnt_q   <= '0;
			lane_q       <= '0;
			csum_phase_q <= 1'b0;
			bit_cnt_q    <= '0;
			bit_idx_q    <= '0;
		end else begin
			case (state_q)
				TX_IDLE: begin
					if (pend_q != '0) begin
						word_cnt_q   <= '0;
						csum_phase_q <= 1'b0;
						state_q      <= TX_READ;
					end
				end
				// Address on the read port this cycle
				TX_READ: state_q <= TX_LOAD;
				TX_LOAD: begin
					lane_q    <= '0;
					rd_ptr_q  <= rd_ptr_q + 1'b1;
					bit_cnt_q <= '0;
					state_q   <= TX_START;
				end
				TX_START: begin
					if (bit_end) begin
						bit_cnt_q <= '0;
						bit_idx_q <= '0;
						state_q   <= TX_DATA;
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt_q <= '0;
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == 3'd7) begin
							state_q <= TX_STOP;
						end
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						bit_cnt_q <= '0;
						if (csum_phase_q) begin
							state_q <= TX_IDLE;
						end else if (lane_q != 2'd3) begin
							lane_q  <= lane_q + 1'b1;
							state_q <= TX_START;
						end else if (word_cnt_q != FRAME_WORDS - 1) begin
							word_cnt_q <= word_cnt_q + 1'b1;
							state_q    <= TX_READ;
						end else begin
							// All words out, checksum goes next
							csum_phase_q <= 1'b1;
							state_q      <= TX_START;
						end
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// Byte loading and checksum accumulation
	always_ff @(posedge clk_i) begin
		case (state_q)
			TX_IDLE: csum_q <= '0;
			TX_LOAD: begin
				word_q  <= con_out_i;
				shift_q <= con_out_i[7:0];
				csum_q  <= csum_q + con_out_i[7:0];
			end
			TX_DATA: begin
				if (bit_end) begin
					shift_q <= shift_q >> 1;
				end
			end
			TX_STOP: begin
				if (bit_end && !csum_phase_q) begin
					if (lane_q != 2'd3) begin
						shift_q <= next_byte;
						csum_q  <= csum_q + next_byte;
					end else if (word_cnt_q == FRAME_WORDS - 1) begin
						shift_q <= csum_q;
					end
				end
			end
			default: ;
		endcase
	end

	assign rd_addr_o = rd_ptr_q;

	// Line level decoded from state, high when idle or in stop
	always_comb begin
		case (state_q)
			TX_START: uart_enc_o = 1'b0;
			TX_DATA:  uart_enc_o = shift_q[0];
			default:  uart_enc_o = 1'b1;
		endcase
	end

endmodule

/* hdl/uart_rx_writer.sv */
/*
 * UART receive writer
 * Samples 8N1 characters on the decoder line, writes each good byte
 * into data memory as a single-lane write and flags completed frames
 */
`timescale 1ns/1ps
module uart_rx_writer (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 uart_dec_i,
	output mcu_io_pkg::dm_addr_t con_addr_o,
	output mcu_io_pkg::dm_be_t   con_write_o,
	output mcu_io_pkg::dm_data_t con_in_o,
	output logic                 int_sig_o,
	output logic                 frame_err_o
);
	import mcu_io_pkg::*;

	// Input synchronizer
	logic rx_meta_q;
	logic rx_sync_q;

	// Receive FSM
	rx_state_t  state_q;
	bit_cnt_t   bit_cnt_q;
	logic [2:0] bit_idx_q;
	uart_byte_t shift_q;
	logic       brk_q;
	logic       frame_err_q;

	// Write side
	logic [DM_AW+1:0]               byte_ptr_q;
	logic [$clog2(FRAME_BYTES)-1:0] frm_cnt_q;
	dm_be_t                         be_q;
	dm_data_t                       wdata_q;
	logic                           int_sig_q;

	logic bit_end;
	logic byte_ok;

	assign bit_end = (bit_cnt_q == BIT_END);
	// Stop bit sampled high at mid-bit
	assign byte_ok = (state_q == RX_STOP) && !brk_q && bit_end && rx_sync_q;

	// Line idles high
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
		end else begin
			rx_meta_q <= uart_dec_i;
			rx_sync_q <= rx_meta_q;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= RX_IDLE;
			bit_cnt_q   <= '0;
			bit_idx_q   <= '0;
			brk_q       <= 1'b0;
			frame_err_q <= 1'b0;
		end else begin
			frame_err_q <= 1'b0;
			case (state_q)
				RX_IDLE: begin
					bit_cnt_q <= '0;
					// First low sample starts a character
					if (!rx_sync_q) begin
						state_q <= RX_START;
					end
				end
				RX_START: begin
					if (bit_cnt_q == HALF_END) begin
						bit_cnt_q <= '0;
						bit_idx_q <= '0;
						// High again at mid start bit means a glitch
						state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_cnt_q <= '0;
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == 3'd7) begin
							state_q <= RX_STOP;
						end
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				RX_STOP: begin
					if (brk_q) begin
						// Hold off until the broken stop bit releases the line
						if (rx_sync_q) begin
							brk_q   <= 1'b0;
							state_q <= RX_IDLE;
						end
					end else if (bit_end) begin
						bit_cnt_q <= '0;
						if (rx_sync_q) begin
							state_q <= RX_IDLE;
						end else begin
							brk_q       <= 1'b1;
							frame_err_q <= 1'b1;
						end
					end else begin
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk_i) begin
		if (state_q == RX_DATA && bit_end) begin
			shift_q <= {rx_sync_q, shift_q[7:1]};
		end
		if (byte_ok) begin
			wdata_q <= {4{shift_q}};
		end
	end

	// Write one cycle after the stop sample, pointer moves after the write
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			be_q       <= '0;
			byte_ptr_q <= '0;
			frm_cnt_q  <= '0;
			int_sig_q  <= 1'b0;
		end else begin
			int_sig_q <= 1'b0;
			be_q      <= byte_ok ? (dm_be_t'(1) << byte_ptr_q[1:0]) : '0;
			if (be_q != '0) begin
				byte_ptr_q <= byte_ptr_q + 1'b1;
				// Frame closes on its last byte write
				if (frm_cnt_q == FRAME_BYTES - 1) begin
					frm_cnt_q <= '0;
					int_sig_q <= 1'b1;
				end else begin
					frm_cnt_q <= frm_cnt_q + 1'b1;
				end
			end
		end
	end

	// Word address and lane from the running byte pointer
	assign con_addr_o  = byte_ptr_q[DM_AW+1:2];
	assign con_write_o = be_q;
	assign con_in_o    = wdata_q;
	assign int_sig_o   = int_sig_q;
	assign frame_err_o = frame_err_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MCU I/O testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mcu_io \
	-f filelist.f -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

grep -qx "SIMULATION PASSED" "$LOG"
if [ $? -eq 0 ] && [ $status -eq 0 ]; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/frame_input.txt */
# Columns: flag (G good character, E broken stop bit) then data byte in hex
# Good bytes form frames of 16, each dumped with a checksum byte
G 41
G 42
G 00
G ff
G 55
E 99
G aa
G 10
G 20
G 30
G 7e
G 81
G c3
G 3c
G 01
G 80
G 5a
G 13
G 24
G 35
G 46
G 57
G 68
G 79
G 8a
G 9b
G ac
G bd
G ce
G df
G e0
G f1
G 02

/* testbench/tb_clkgen.sv */
/*
 * Testbench clock source
 * Free-running clock with a 10 ns period
 */
`timescale 1ns/1ps
module tb_clkgen (
	output logic clk_o
);
	// Half of the 10 ns period
	localparam int HALF_PERIOD = 5;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

endmodule

/* testbench/tb_mcu_io.sv */
/*
 * Testbench for the MCU protocol-controller I/O top level
 * Sends characters from the stimulus file on the decoder line and
 * checks dumped frames, checksums and strobe pulse totals
 */
`timescale 1ns/1ps
module tb_mcu_io;
	import mcu_io_pkg::*;

	localparam string STIM_FILE   = "testbench/frame_input.txt";
	localparam int    MAX_GAP     = 20;
	localparam int    IDLE_CYCLES = 50;

	logic clk;
	logic arst_n;
	logic uart_dec;
	logic uart_enc;
	logic int_sig;
	logic frame_err;

	// Characters to send and bytes expected back
	uart_byte_t chr_q[$];
	logic       good_q[$];
	uart_byte_t exp_q[$];

	int cycles;
	int limit;
	int exp_frames;
	int exp_errs;
	int int_cnt;
	int err_cnt;
	int low_cnt;
	int out_idx;
	bit idle_phase;

	tb_clkgen tb_clkgen_i (
		.clk_o (clk)
	);

	mcu_io_top mcu_io_top_i (
		.clk_i       (clk),
		.arst_n_i    (arst_n),
		.uart_dec_i  (uart_dec),
		.uart_enc_o  (uart_enc),
		.int_sig_o   (int_sig),
		.frame_err_o (frame_err)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	// Good bytes grouped in frames, checksum after every 16th
	task automatic read_stimulus(output int n_chars);
		int         fd;
		int         n_good;
		string      line;
		byte        flag;
		uart_byte_t val;
		uart_byte_t sum;
		n_chars = 0;
		n_good  = 0;
		sum     = '0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			stop_on_error("Could not open the stimulus file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Comment lines fail the flag test
				if ($sscanf(line, "%c %h", flag, val) == 2 && (flag == "G" || flag == "E")) begin
					chr_q.push_back(val);
					good_q.push_back(flag == "G");
					n_chars++;
					if (flag == "G") begin
						exp_q.push_back(val);
						sum = sum + val;
						n_good++;
						if (n_good % FRAME_BYTES == 0) begin
							exp_q.push_back(sum);
							sum = '0;
						end
					end else begin
						exp_errs++;
					end
				end
			end
			$fclose(fd);
			exp_frames = n_good / FRAME_BYTES;
		end
	endtask

	// One bit period, set just after a rising edge
	task automatic drive_bit(input logic v);
		uart_dec <= v;
		repeat (CLKS_PER_BIT) @(posedge clk);
	endtask

	task automatic send_char(input uart_byte_t b, input logic good);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(b[i]);
		end
		if (good) begin
			drive_bit(1'b1);
		end else begin
			// Broken stop bit, then release the line
			drive_bit(1'b0);
			drive_bit(1'b1);
		end
	endtask

	// Strobe totals and idle line watch
	always @(negedge clk) begin
		if (arst_n === 1'b1) begin
			if (int_sig === 1'b1) int_cnt++;
			if (frame_err === 1'b1) err_cnt++;
			if (idle_phase && uart_enc !== 1'b1) low_cnt++;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			stop_on_error($sformatf("Timeout after %0d cycles, %0d output bytes never arrived",
				cycles, exp_q.size()));
		end
	end

	// Serial monitor, samples at mid-bit after each start edge
	initial begin : capture_tx
		uart_byte_t rx_byte;
		string      name;
		wait (arst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (uart_enc === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				if (uart_enc !== 1'b0) stop_on_error("Start bit on uart_enc_o ended before mid-bit");
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					rx_byte[i] = uart_enc;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (uart_enc !== 1'b1) stop_on_error("Stop bit on uart_enc_o was low");
				if (exp_q.size() == 0) begin
					stop_on_error($sformatf("Unexpected extra byte %02h on uart_enc_o", rx_byte));
				end else begin
					// 16 data bytes then the checksum
					if (out_idx % (FRAME_BYTES + 1) == FRAME_BYTES) begin
						name = $sformatf("frame %0d checksum", out_idx / (FRAME_BYTES + 1));
					end else begin
						name = $sformatf("frame %0d byte %0d", out_idx / (FRAME_BYTES + 1),
							out_idx % (FRAME_BYTES + 1));
					end
					check_byte(name, exp_q.pop_front(), rx_byte);
					out_idx++;
				end
			end
		end
	end

	initial begin
		int n_chars;
		int gap;
		int good_sent;
		uart_dec   = 1'b1;
		arst_n     = 1'b0;
		cycles     = 0;
		limit      = 0;
		exp_frames = 0;
		exp_errs   = 0;
		int_cnt    = 0;
		err_cnt    = 0;
		low_cnt    = 0;
		out_idx    = 0;
		idle_phase = 1'b0;
		good_sent  = 0;
		void'($urandom(32'h7af6_5930));
		read_stimulus(n_chars);
		limit = n_chars * 10 * CLKS_PER_BIT * 3 + 2000;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		// Quiet window before any stimulus
		idle_phase = 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk);
		idle_phase = 1'b0;
		check_count("idle uart_enc_o low cycles", 0, low_cnt);
		check_count("idle int_sig_o pulses", 0, int_cnt);
		check_count("idle frame_err_o pulses", 0, err_cnt);
		for (int i = 0; i < chr_q.size(); i++) begin
			send_char(chr_q[i], good_q[i]);
			if (good_q[i]) good_sent++;
			// Random gaps in the first frame, later frames back to back
			gap = (good_sent < FRAME_BYTES) ? int'($urandom % (MAX_GAP + 1)) : 0;
			repeat (gap) @(posedge clk);
		end
		while (exp_q.size() != 0) @(posedge clk);
		// Room for any stray byte to show up
		repeat (20 * CLKS_PER_BIT) @(posedge clk);
		check_count("int_sig_o pulses", exp_frames, int_cnt);
		check_count("frame_err_o pulses", exp_errs, err_cnt);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
